// File: sources.f
+incdir+verilog
verilog/qla_pkg.sv
verilog/axil_reg_bridge.sv
verilog/ctrl_dac.sv
verilog/ctrl_enc.sv
verilog/board_regs.sv
verilog/motor_ctrl_top.sv
tests/tb_motor_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_motor_ctrl -o sim_motor_ctrl > build.log 2>&1 \
    && ./obj_dir/sim_motor_ctrl > sim.log 2>&1 \
    || echo "build or simulation stopped with an error"
grep -qx "All tests passed!" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: tests/tb_motor_ctrl.sv
/* testbench for the motor controller register core, drives AXI4-Lite and the board pins
   checks dac frames, encoder counts, enables, watchdog and back-pressure */
`timescale 1ns/1ps
`include "qla_consts.svh"

module tb_motor_ctrl;

    localparam int WAIT_LIMIT  = 100;       // cycles per handshake wait
    localparam int FRAME_LIMIT = 400;       // cycles for a dac frame to show up

    logic        sysclk, rst_n;
    logic [7:0]  awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb, enc_a, enc_b, fault, amp_enable;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [1:0]  bresp, rresp;
    logic        dac_sclk, dac_mosi, dac_csn;

    logic [15:0]         lfsr_state = 16'd94;   // seed
    logic [1:0]          quad_phase [4];        // 0..3 = ab 00,10,11,01
    qla_pkg::dac_frame_t frames [$];            // captured off the wire
    logic [23:0]         cap_shift = '0;
    int                  cap_bits = 0;
    logic                r_hold = 1'b0;
    logic                b_hold = 1'b0;
    logic [31:0]         rdata_held = '0;

    motor_ctrl_top i_dut (.*);

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;           // 100 ns
    end

    // --------------------
    // reporting and random bits
    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);     // galois x^16+x^14+x^13+x^11+1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};       // one step per bit
        end
    endtask

    // status word with id in 27:24, wdog 16, fault 11:8 and enables 3:0
    function automatic logic [31:0] status_word(input logic wd, input logic [3:0] flt,
                                                input logic [3:0] en);
        logic [31:0] w;
        w        = '0;
        w[27:24] = `QLA_BOARD_ID;
        w[16]    = wd;
        w[11:8]  = flt;
        w[3:0]   = en;
        return w;
    endfunction

    // --------------------
    // AXI4-Lite master
    task automatic await_write_accept();
        int n = 0;
        do begin
            @(negedge sysclk);
            n++;
        end while (!awready && n < WAIT_LIMIT);
        if (!awready) begin
            $display("timeout waiting for the bridge to accept a write");
            stop_with_failure();
        end
        check_equal("wready", 32'(wready), 32'h1);  // aw and w go together
    endtask

    task automatic issue_write(input logic [7:0] a, input logic [31:0] d);
        @(posedge sysclk);
        awaddr  <= a;
        wdata   <= d;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        await_write_accept();
    endtask

    task automatic collect_write();
        logic [31:0] stall;
        int n = 0;
        do begin
            @(negedge sysclk);
            n++;
        end while (!bvalid && n < WAIT_LIMIT);
        if (!bvalid) begin
            $display("timeout waiting for the write response");
            stop_with_failure();
        end
        check_equal("bresp", 32'(bresp), 32'h0);
        rand_bits(3, stall);
        repeat (stall) @(posedge sysclk);           // hold bready low a while
        @(posedge sysclk);
        bready <= 1'b1;
        @(posedge sysclk);
        bready <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
        issue_write(a, d);
        @(posedge sysclk);                          // accepting edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        collect_write();
    endtask

    task automatic await_read_accept();
        int n = 0;
        do begin
            @(negedge sysclk);
            n++;
        end while (!arready && n < WAIT_LIMIT);
        if (!arready) begin
            $display("timeout waiting for the bridge to accept a read");
            stop_with_failure();
        end
    endtask

    task automatic issue_read(input logic [7:0] a);
        @(posedge sysclk);
        araddr  <= a;
        arvalid <= 1'b1;
        await_read_accept();
    endtask

    task automatic collect_read(output logic [31:0] d);
        logic [31:0] stall;
        int n = 0;
        do begin
            @(negedge sysclk);
            n++;
        end while (!rvalid && n < WAIT_LIMIT);
        if (!rvalid) begin
            $display("timeout waiting for read data");
            stop_with_failure();
        end
        check_equal("rresp", 32'(rresp), 32'h0);
        rand_bits(3, stall);
        repeat (stall) @(posedge sysclk);           // rready low a while
        @(posedge sysclk);
        rready <= 1'b1;
        @(negedge sysclk);
        d = rdata;                                  // taken at the next edge
        @(posedge sysclk);
        rready <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] a, output logic [31:0] d);
        issue_read(a);
        @(posedge sysclk);
        arvalid <= 1'b0;
        collect_read(d);
    endtask

    // --------------------
    // quadrature model and dac capture
    task automatic quad_move(input int axis, input int steps, input bit fwd);
        logic [1:0] p;
        for (int s = 0; s < steps; s++) begin
            p = fwd ? quad_phase[axis] + 2'd1 : quad_phase[axis] - 2'd1;
            quad_phase[axis] = p;
            @(posedge sysclk);
            enc_a[axis] <= (p == 2'd1 || p == 2'd2);
            enc_b[axis] <= (p == 2'd2 || p == 2'd3);
            repeat (3) @(posedge sysclk);           // sync + decode
        end
    endtask

    always @(posedge dac_sclk or posedge dac_csn) begin
        if (dac_csn) begin                          // frame closed
            if (cap_bits != 0) begin
                assert (cap_bits == `QLA_DAC_FRAME_W) else begin
                    $display("dac frame had %0d bits instead of 24", cap_bits);
                    stop_with_failure();
                end
                frames.push_back(qla_pkg::dac_frame_t'(cap_shift));
            end
            cap_bits = 0;
        end else begin
            cap_shift = {cap_shift[22:0], dac_mosi};  // msb first
            cap_bits++;
        end
    end

    task automatic wait_frame();
        int n = 0;
        do begin
            @(negedge sysclk);
            n++;
        end while (frames.size() == 0 && n < FRAME_LIMIT);
        if (frames.size() == 0) begin
            $display("no dac frame arrived after the command write");
            stop_with_failure();
        end
    endtask

    // link idle for a full frame time
    task automatic wait_dac_quiet();
        int n = 0;
        int quiet = 0;
        do begin
            @(negedge sysclk);
            n++;
            quiet = dac_csn ? quiet + 1 : 0;
        end while (quiet < 60 && n < FRAME_LIMIT);
        if (quiet < 60) begin
            $display("dac link never went quiet");
            stop_with_failure();
        end
    endtask

    // --------------------
    // protocol checks
    a_no_wr_while_b: assert property (@(posedge sysclk) disable iff (!rst_n)
                                      !(bvalid && awready)) else begin
        $display("a write was accepted while the write response was pending");
        stop_with_failure();
    end

    a_no_rd_while_r: assert property (@(posedge sysclk) disable iff (!rst_n)
                                      !(rvalid && arready)) else begin
        $display("a read was accepted while read data was pending");
        stop_with_failure();
    end

    always @(posedge sysclk) begin
        if (r_hold) begin
            assert (rvalid) else begin
                $display("rvalid dropped while rready was low");
                stop_with_failure();
            end
            check_equal("rdata (held)", rdata, rdata_held);
        end
        if (b_hold) begin
            assert (bvalid) else begin
                $display("bvalid dropped while bready was low");
                stop_with_failure();
            end
        end
        r_hold     <= rst_n && rvalid && !rready;
        b_hold     <= rst_n && bvalid && !bready;
        rdata_held <= rdata;
    end

    // --------------------
    // test sequence
    initial begin
        logic [31:0]         v, v2, d, d2, pre;
        logic [23:0]         exp24;
        qla_pkg::dac_frame_t exp_f;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        enc_a   = '0;
        enc_b   = '0;
        fault   = 4'b0100;                          // axis 3 faulted
        for (int i = 0; i < 4; i++)
            quad_phase[i] = 2'd0;
        repeat (2) @(posedge sysclk);
        rst_n <= 1'b1;

        // reset state
        @(negedge sysclk);
        check_equal("bvalid", 32'(bvalid), 32'h0);
        check_equal("rvalid", 32'(rvalid), 32'h0);
        check_equal("awready", 32'(awready), 32'h0);
        check_equal("wready", 32'(wready), 32'h0);
        check_equal("arready", 32'(arready), 32'h0);
        check_equal("dac_csn", 32'(dac_csn), 32'h1);
        check_equal("dac_sclk", 32'(dac_sclk), 32'h0);
        check_equal("amp_enable", 32'(amp_enable), 32'h0);

        // dac command, read-back and frame for every axis
        for (int ax = 1; ax <= 4; ax++) begin
            rand_bits(16, v);
            frames.delete();
            write_reg({4'(ax), 4'h1}, v);
            read_reg({4'(ax), 4'h1}, d);
            check_equal("dac read-back", d, v);
            wait_frame();
            exp_f.command = 4'h3;
            exp_f.channel = 4'(ax - 1);
            exp_f.value   = v[15:0];
            check_equal("dac frame", 32'(frames.pop_front()), 32'(exp_f));
        end
        // two quick writes to one axis end with the last value
        rand_bits(16, v);
        rand_bits(16, v2);
        frames.delete();
        write_reg(8'h21, v);
        write_reg(8'h21, v2);
        wait_dac_quiet();
        exp_f.channel = 4'h1;
        exp_f.value   = v2[15:0];
        check_equal("last dac frame", 32'(frames[$]), 32'(exp_f));

        // encoder axis 2 counts forward from a random preload
        rand_bits(24, pre);
        write_reg(8'h24, pre);
        quad_move(1, 10, 1'b1);
        repeat (4) @(posedge sysclk);
        read_reg(8'h25, d);
        exp24 = pre[23:0] + 24'd10;
        check_equal("enc count fwd", d, {{8{exp24[23]}}, exp24});
        read_reg(8'h24, d);
        check_equal("enc preload read", d, 32'h0);
        // reverse through zero gives a sign-extended count
        write_reg(8'h24, 32'h3);
        quad_move(1, 7, 1'b0);
        repeat (4) @(posedge sysclk);
        read_reg(8'h25, d);
        exp24 = 24'd3 - 24'd7;
        check_equal("enc count rev", d, {{8{exp24[23]}}, exp24});

        // enables masked by faults
        write_reg(8'h00, 32'hF);
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        check_equal("amp_enable", 32'(amp_enable), 32'(4'hF & ~fault));
        read_reg(8'h00, d);
        check_equal("status", d, status_word(1'b0, fault, 4'hF & ~fault));

        // reads do not count as host activity for the watchdog
        repeat (`QLA_WDOG_CYCLES + 20) @(posedge sysclk);
        @(negedge sysclk);
        check_equal("amp_enable after wdog", 32'(amp_enable), 32'h0);
        read_reg(8'h00, d);
        check_equal("status after wdog", d, status_word(1'b1, fault, 4'h0));
        write_reg(8'h00, 32'h3);
        read_reg(8'h00, d);
        check_equal("status wdog cleared", d, status_word(1'b0, fault, 4'h3 & ~fault));

        // back-pressure with a second transfer offered while the first is held
        rand_bits(16, v);
        rand_bits(16, v2);
        issue_write(8'h31, v);
        @(posedge sysclk);
        awaddr <= 8'h41;
        wdata  <= v2;
        collect_write();
        await_write_accept();                       // taken once the response is gone
        @(posedge sysclk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        collect_write();
        issue_read(8'h31);
        @(posedge sysclk);
        araddr <= 8'h41;
        collect_read(d);
        await_read_accept();
        @(posedge sysclk);
        arvalid <= 1'b0;
        collect_read(d2);
        check_equal("rdata axis 3", d, v & 32'hFFFF);
        check_equal("rdata axis 4", d2, v2 & 32'hFFFF);

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: verilog/motor_ctrl_top.sv
/* register core of the four axis motor controller, host access over AXI4-Lite
   ties the bridge to the dac, encoder and board blocks and muxes read data */
`timescale 1ns/1ps
`include "qla_consts.svh"

module motor_ctrl_top (
    input  logic                       sysclk,
    input  logic                       rst_n,
    // host, AXI4-Lite
    input  logic [`QLA_ADDR_W-1:0]     awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`QLA_DATA_W-1:0]     wdata,
    input  logic [`QLA_DATA_W/8-1:0]   wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic                       bvalid,
    output logic [1:0]                 bresp,
    input  logic                       bready,
    input  logic [`QLA_ADDR_W-1:0]     araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic                       rvalid,
    output logic [`QLA_DATA_W-1:0]     rdata,
    output logic [1:0]                 rresp,
    input  logic                       rready,
    // board pins
    output logic                       dac_sclk,
    output logic                       dac_mosi,
    output logic                       dac_csn,
    output logic [`QLA_NUM_AXES-1:0]   amp_enable,
    input  logic [`QLA_NUM_AXES-1:0]   enc_a,
    input  logic [`QLA_NUM_AXES-1:0]   enc_b,
    input  logic [`QLA_NUM_AXES-1:0]   fault
);

    qla_pkg::reg_wr_t       reg_wr;
    qla_pkg::reg_rd_t       reg_rd;
    logic [`QLA_DATA_W-1:0] reg_rdata;
    logic [`QLA_DATA_W-1:0] rdata_dac;
    logic [`QLA_DATA_W-1:0] rdata_enc;
    logic [`QLA_DATA_W-1:0] rdata_chan0;

    // --------------------
    // read data by address, channel 0 is the board itself
    always_comb begin
        if (reg_rd.addr[7:4] == `QLA_CHAN_BOARD)
            reg_rdata = rdata_chan0;
        else if (reg_rd.addr[3:0] == `QLA_DEV_DAC)
            reg_rdata = rdata_dac;
        else if (reg_rd.addr[3:0] == `QLA_DEV_PRELOAD || reg_rd.addr[3:0] == `QLA_DEV_QUAD)
            reg_rdata = rdata_enc;
        else
            reg_rdata = '0;         // unmapped
    end

    axil_reg_bridge bridge (
        .sysclk(sysclk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_rdata(reg_rdata)
    );

    // motor current commands out to the quad dac
    ctrl_dac dac (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wr(reg_wr), .reg_rd(reg_rd), .rdata(rdata_dac),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csn(dac_csn)
    );

    ctrl_enc enc (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wr(reg_wr), .reg_rd(reg_rd), .rdata(rdata_enc),
        .enc_a(enc_a), .enc_b(enc_b)
    );

    board_regs chan0 (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wr(reg_wr), .reg_rd(reg_rd), .rdata(rdata_chan0),
        .fault(fault), .amp_enable(amp_enable)
    );

endmodule

// File: verilog/board_regs.sv
/* channel 0 board registers: id, fault inputs, amplifier enables
   a host watchdog drops the enables when register writes stop */
`timescale 1ns/1ps
`include "qla_consts.svh"

module board_regs (
    input  logic                     sysclk,
    input  logic                     rst_n,
    input  qla_pkg::reg_wr_t         reg_wr,
    input  qla_pkg::reg_rd_t         reg_rd,
    output logic [`QLA_DATA_W-1:0]   rdata,
    input  logic [`QLA_NUM_AXES-1:0] fault,
    output logic [`QLA_NUM_AXES-1:0] amp_enable
);

    localparam int WD_W = $clog2(`QLA_WDOG_CYCLES + 1);

    logic [`QLA_NUM_AXES-1:0] fault_s1, fault_s2;
    logic [`QLA_NUM_AXES-1:0] en_req_q;     // host enable request
    logic [WD_W-1:0]          wdog_cnt_q;   // 0 = not armed / expired
    logic                     wdog_flag_q;  // latched timeout
    logic                     ch0_wr;
    logic                     stat_wr;

    assign ch0_wr  = reg_wr.wen && (reg_wr.addr[7:4] == `QLA_CHAN_BOARD);
    assign stat_wr = ch0_wr && (reg_wr.addr[3:0] == `QLA_DEV_STATUS);

    assign amp_enable = en_req_q & ~fault_s2;   // faulted axes forced off

    // id 27:24, wdog 16, fault 11:8, enables 3:0
    assign rdata = (reg_rd.ren && reg_rd.addr == {`QLA_CHAN_BOARD, `QLA_DEV_STATUS})
                   ? {4'b0, `QLA_BOARD_ID, 7'b0, wdog_flag_q, 4'b0, fault_s2,
                      4'b0, amp_enable}
                   : '0;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            fault_s1    <= '0;
            fault_s2    <= '0;
            en_req_q    <= '0;
            wdog_cnt_q  <= '0;
            wdog_flag_q <= 1'b0;
        end else begin
            fault_s1 <= fault;
            fault_s2 <= fault_s1;
            // --------------------
            // watchdog, armed by the first write
            if (reg_wr.wen)
                wdog_cnt_q <= WD_W'(`QLA_WDOG_CYCLES);     // any write is host activity
            else if (wdog_cnt_q != '0)
                wdog_cnt_q <= wdog_cnt_q - 1'b1;
            if (!reg_wr.wen && wdog_cnt_q == WD_W'(1)) begin
                en_req_q    <= '0;          // host gone quiet
                wdog_flag_q <= 1'b1;
            end
            if (ch0_wr)
                wdog_flag_q <= 1'b0;
            if (stat_wr)
                en_req_q <= reg_wr.wdata[`QLA_NUM_AXES-1:0];
        end
    end

endmodule

// File: verilog/ctrl_enc.sv
/* quadrature position counters for the four axes
   inputs are synchronized here, counters preload from the register bus */
`timescale 1ns/1ps
`include "qla_consts.svh"

module ctrl_enc (
    input  logic                     sysclk,
    input  logic                     rst_n,
    input  qla_pkg::reg_wr_t         reg_wr,
    input  qla_pkg::reg_rd_t         reg_rd,
    output logic [`QLA_DATA_W-1:0]   rdata,
    input  logic [`QLA_NUM_AXES-1:0] enc_a,
    input  logic [`QLA_NUM_AXES-1:0] enc_b
);

    logic [`QLA_NUM_AXES-1:0] a_s1, a_s2, a_prev;
    logic [`QLA_NUM_AXES-1:0] b_s1, b_s2, b_prev;
    logic [`QLA_ENC_W-1:0]    cnt_q [`QLA_NUM_AXES];
    logic [`QLA_ENC_W-1:0]    rd_cnt;
    logic                     preload_hit;
    logic                     rd_axis_ok;
    qla_pkg::axis_t           wr_axis;
    qla_pkg::axis_t           rd_axis;

    // {prev_a, prev_b, a, b} -> +1 / -1 / 0
    function automatic logic [1:0] quad_step(input logic [3:0] tr);
        case (tr)
            4'b0010, 4'b1011, 4'b1101, 4'b0100: return 2'b01;  // forward
            4'b1000, 4'b1110, 4'b0111, 4'b0001: return 2'b10;  // reverse
            default:                            return 2'b00;  // hold or double step
        endcase
    endfunction

    // --------------------
    // register decode
    assign preload_hit = reg_wr.wen && qla_pkg::is_axis_chan(reg_wr.addr[7:4])
                         && (reg_wr.addr[3:0] == `QLA_DEV_PRELOAD);
    assign wr_axis     = qla_pkg::axis_idx(reg_wr.addr[7:4]);
    assign rd_axis     = qla_pkg::axis_idx(reg_rd.addr[7:4]);
    assign rd_axis_ok  = reg_rd.ren && qla_pkg::is_axis_chan(reg_rd.addr[7:4]);
    assign rd_cnt      = cnt_q[rd_axis];

    // count sign-extended, preload reads as 0
    assign rdata = (rd_axis_ok && reg_rd.addr[3:0] == `QLA_DEV_QUAD)
                   ? {{(`QLA_DATA_W-`QLA_ENC_W){rd_cnt[`QLA_ENC_W-1]}}, rd_cnt}
                   : '0;

    // --------------------
    // sync, 2 flops + last state for the decode
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            a_s1   <= '0;
            a_s2   <= '0;
            a_prev <= '0;
            b_s1   <= '0;
            b_s2   <= '0;
            b_prev <= '0;
        end else begin
            a_s1   <= enc_a;
            a_s2   <= a_s1;
            a_prev <= a_s2;
            b_s1   <= enc_b;
            b_s2   <= b_s1;
            b_prev <= b_s2;
        end
    end

    // counters, preload beats a step in the same cycle
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++)
                cnt_q[i] <= '0;
        end else begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (preload_hit && wr_axis == qla_pkg::axis_t'(i))
                    cnt_q[i] <= reg_wr.wdata[`QLA_ENC_W-1:0];
                else if (quad_step({a_prev[i], b_prev[i], a_s2[i], b_s2[i]}) == 2'b01)
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                else if (quad_step({a_prev[i], b_prev[i], a_s2[i], b_s2[i]}) == 2'b10)
                    cnt_q[i] <= cnt_q[i] - 1'b1;
            end
        end
    end

endmodule

// File: verilog/ctrl_dac.sv
/* current command registers for the four axes and the serial link to the quad dac
   changed commands are queued per axis and sent lowest axis first */
`timescale 1ns/1ps
`include "qla_consts.svh"

module ctrl_dac (
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  qla_pkg::reg_wr_t       reg_wr,
    input  qla_pkg::reg_rd_t       reg_rd,
    output logic [`QLA_DATA_W-1:0] rdata,
    output logic                   dac_sclk,
    output logic                   dac_mosi,
    output logic                   dac_csn
);

    localparam int CNT_W = $clog2(`QLA_DAC_FRAME_W);

    logic [`QLA_DAC_W-1:0]       cmd_q [`QLA_NUM_AXES];
    logic [`QLA_NUM_AXES-1:0]    pend_q;        // value changed, not yet sent
    logic                        wr_hit;
    logic                        rd_hit;
    qla_pkg::axis_t              wr_axis;
    qla_pkg::axis_t              rd_axis;
    qla_pkg::axis_t              next_axis;
    logic                        take;
    qla_pkg::dac_frame_t         frame;
    logic [`QLA_DAC_FRAME_W-1:0] shift_q;
    logic [CNT_W-1:0]            bit_cnt;
    logic                        busy_q;

    // --------------------
    // register decode
    assign wr_hit  = reg_wr.wen && qla_pkg::is_axis_chan(reg_wr.addr[7:4])
                     && (reg_wr.addr[3:0] == `QLA_DEV_DAC);
    assign rd_hit  = reg_rd.ren && qla_pkg::is_axis_chan(reg_rd.addr[7:4])
                     && (reg_rd.addr[3:0] == `QLA_DEV_DAC);
    assign wr_axis = qla_pkg::axis_idx(reg_wr.addr[7:4]);
    assign rd_axis = qla_pkg::axis_idx(reg_rd.addr[7:4]);

    assign rdata = rd_hit ? {{(`QLA_DATA_W-`QLA_DAC_W){1'b0}}, cmd_q[rd_axis]} : '0;

    always_ff @(posedge sysclk) begin
        if (wr_hit)
            cmd_q[wr_axis] <= reg_wr.wdata[`QLA_DAC_W-1:0];
    end

    // lowest pending axis wins
    always_comb begin
        next_axis = '0;
        for (int i = `QLA_NUM_AXES - 1; i >= 0; i--) begin
            if (pend_q[i])
                next_axis = qla_pkg::axis_t'(i);
        end
    end

    assign take  = (|pend_q) && !busy_q;
    assign frame = '{command: `QLA_DAC_CMD_WRUPD,
                     channel: 4'(next_axis),
                     value:   cmd_q[next_axis]};

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            pend_q <= '0;
        else begin
            if (take)
                pend_q[next_axis] <= 1'b0;
            if (wr_hit)
                pend_q[wr_axis] <= 1'b1;    // new write re-queues, last value goes out
        end
    end

    // --------------------
    // shifter, sclk = sysclk / 2
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            dac_csn  <= 1'b1;
            dac_sclk <= 1'b0;
            bit_cnt  <= '0;
            shift_q  <= '0;
        end else if (!busy_q) begin
            if (take) begin
                busy_q  <= 1'b1;
                dac_csn <= 1'b0;            // frame start
                shift_q <= frame;
                bit_cnt <= CNT_W'(`QLA_DAC_FRAME_W - 1);
            end
        end else if (!dac_sclk) begin
            dac_sclk <= 1'b1;               // dac samples mosi here
        end else begin
            dac_sclk <= 1'b0;
            if (bit_cnt == '0) begin
                busy_q  <= 1'b0;
                dac_csn <= 1'b1;            // frame done
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
                shift_q <= {shift_q[`QLA_DAC_FRAME_W-2:0], 1'b0};
            end
        end
    end

    assign dac_mosi = shift_q[`QLA_DAC_FRAME_W-1];  // msb first

endmodule

// File: verilog/axil_reg_bridge.sv
/* AXI4-Lite slave in front of the board register bus
   one write or read in flight per direction, writes win a tie */
`timescale 1ns/1ps
`include "qla_consts.svh"

module axil_reg_bridge (
    input  logic                       sysclk,
    input  logic                       rst_n,
    // write address / data / response
    input  logic [`QLA_ADDR_W-1:0]     awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`QLA_DATA_W-1:0]     wdata,
    input  logic [`QLA_DATA_W/8-1:0]   wstrb,   // strobes not decoded
    input  logic                       wvalid,
    output logic                       wready,
    output logic                       bvalid,
    output logic [1:0]                 bresp,
    input  logic                       bready,
    // read address / data
    input  logic [`QLA_ADDR_W-1:0]     araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic                       rvalid,
    output logic [`QLA_DATA_W-1:0]     rdata,
    output logic [1:0]                 rresp,
    input  logic                       rready,
    // register bus
    output qla_pkg::reg_wr_t           reg_wr,
    output qla_pkg::reg_rd_t           reg_rd,
    input  logic [`QLA_DATA_W-1:0]     reg_rdata
);

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_BUSY} rd_state_t;

    wr_state_t              wr_state;
    rd_state_t              rd_state;
    logic                   wr_accept;
    logic                   rd_accept;
    logic                   wen_q;      // register bus write strobe
    logic                   ren_q;      // fetch cycle
    logic                   rvalid_q;
    logic [`QLA_ADDR_W-1:0] waddr_q;
    logic [`QLA_DATA_W-1:0] wdata_q;
    logic [`QLA_ADDR_W-1:0] raddr_q;
    logic [`QLA_DATA_W-1:0] rdata_q;

    // --------------------
    // acceptance
    assign wr_accept = awvalid && wvalid && (wr_state == WR_IDLE);
    assign rd_accept = arvalid && (rd_state == RD_IDLE) && !wr_accept;  // write first

    assign awready = wr_accept;         // aw and w taken together
    assign wready  = wr_accept;
    assign arready = rd_accept;

    assign bvalid = (wr_state == WR_RESP);
    assign bresp  = 2'b00;              // always OKAY
    assign rvalid = rvalid_q;
    assign rdata  = rdata_q;
    assign rresp  = 2'b00;

    // --------------------
    // control state
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
            rd_state <= RD_IDLE;
            wen_q    <= 1'b0;
            ren_q    <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            wen_q <= wr_accept;         // one cycle pulse
            ren_q <= rd_accept;
            if (wr_accept)
                wr_state <= WR_RESP;
            else if (bvalid && bready)
                wr_state <= WR_IDLE;
            if (rd_accept)
                rd_state <= RD_BUSY;
            if (ren_q)
                rvalid_q <= 1'b1;       // data captured this edge
            else if (rvalid_q && rready) begin
                rvalid_q <= 1'b0;
                rd_state <= RD_IDLE;
            end
        end
    end

    // payload registers
    always_ff @(posedge sysclk) begin
        if (wr_accept) begin
            waddr_q <= awaddr;
            wdata_q <= wdata;
        end
        if (rd_accept)
            raddr_q <= araddr;
        if (ren_q)
            rdata_q <= reg_rdata;       // cuts the path from block decode
    end

    assign reg_wr = '{wen: wen_q, addr: waddr_q, wdata: wdata_q};
    assign reg_rd = '{ren: ren_q, addr: raddr_q};

endmodule

// File: verilog/qla_pkg.sv
/* register bus and dac frame types shared by the bridge and the channel blocks
   plus the small helpers that turn a channel nibble into an axis index */
`include "qla_consts.svh"

package qla_pkg;

    localparam int AXIS_W = $clog2(`QLA_NUM_AXES);

    typedef logic [AXIS_W-1:0] axis_t;      // axis 0..3 = channel 1..4

    // one register write, wen is a single cycle pulse
    typedef struct packed {
        logic                   wen;
        logic [`QLA_ADDR_W-1:0] addr;
        logic [`QLA_DATA_W-1:0] wdata;
    } reg_wr_t;

    // one register read request
    typedef struct packed {
        logic                   ren;
        logic [`QLA_ADDR_W-1:0] addr;
    } reg_rd_t;

    // frame as it goes out on the wire, msb first
    typedef struct packed {
        logic [3:0]            command;     // always write and update
        logic [3:0]            channel;     // dac output = axis
        logic [`QLA_DAC_W-1:0] value;
    } dac_frame_t;

    // true for channels that map onto an axis
    function automatic logic is_axis_chan(input logic [3:0] chan);
        return (chan != `QLA_CHAN_BOARD) && (chan <= 4'(`QLA_NUM_AXES));
    endfunction

    function automatic axis_t axis_idx(input logic [3:0] chan);
        return axis_t'(chan - 4'd1);        // channel 1 -> axis 0
    endfunction

endpackage

// File: verilog/qla_consts.svh
/* address map, device codes and sizing for the motor controller register core
   included by the package and by every block that decodes the register bus */
`ifndef QLA_CONSTS_SVH
`define QLA_CONSTS_SVH

// --------------------
// register bus
`define QLA_ADDR_W        8         // {channel, device}
`define QLA_DATA_W        32
`define QLA_NUM_AXES      4         // channels 1..4
`define QLA_CHAN_BOARD    4'd0      // board itself

// device codes, low address nibble
`define QLA_DEV_STATUS    4'd0      // channel 0 only
`define QLA_DEV_DAC       4'd1      // current command
`define QLA_DEV_PRELOAD   4'd4      // encoder preload, write only
`define QLA_DEV_QUAD      4'd5      // encoder count

// --------------------
// datapath widths
`define QLA_ENC_W         24
`define QLA_DAC_W         16

// quad dac serial frame: command, channel, value
`define QLA_DAC_FRAME_W   24
`define QLA_DAC_CMD_WRUPD 4'h3      // write and update

// --------------------
// board
`define QLA_WDOG_CYCLES   2000      // sysclk cycles of host silence
`define QLA_BOARD_ID      4'h5

`endif
